// ==== include/fetch_params.svh ====
//////////////////////////////////////////////////
// fetch subsystem constants: boot pc, buffer depth
// and machine csr numbers
//////////////////////////////////////////////////

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address after reset
`define FETCH_BOOT_PC 32'h8000_0000

// log2 of instruction buffer depth
`define FETCH_BUF_POT 3

// machine trap vector base
`define CSR_ADDR_MTVEC 12'h305

// machine exception pc
`define CSR_ADDR_MEPC 12'h341

`endif

// ==== verilog/fetch_pkg.sv ====
//////////////////////////////////////////////////
// fetch types: wishbone bundles, cpu port, redirect,
// csr write port, mtvec and mcause layouts
//////////////////////////////////////////////////

package fetch_pkg;

    // wishbone pipelined, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        logic [31:0] wdata;
    } wb_req_t;

    // wishbone pipelined, slave to master
    typedef struct packed {
        logic        ack;
        logic        stall;
        logic [31:0] rdata;
    } wb_rsp_t;

    // instruction word presented to the cpu
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_out_t;

    // source of a redirect target
    typedef enum logic [1:0] {
        PC_JUMP = 2'b00,
        PC_MEPC = 2'b01,
        PC_TRAP = 2'b10
    } pc_sel_t;

    // redirect request from the controller, one cycle pulse on en
    typedef struct packed {
        logic        en;
        pc_sel_t     sel;
        logic [31:0] branch_target;
    } redirect_t;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_t;

    // same bit layout as the architectural mtvec register
    typedef struct packed {
        logic [29:0] base;
        mtvec_mode_t mode;
    } mtvec_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] trap_code;
    } mcause_t;

    typedef struct packed {
        logic        we;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wr_t;

endpackage

// ==== verilog/sync_fifo.sv ====
//////////////////////////////////////////////////
// synchronous fifo with typed payload, fill count
// and synchronous clear
//////////////////////////////////////////////////

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH_POT = 3
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               clear_i,
    input  logic               wr_i,
    input  payload_t           wdata_i,
    input  logic               rd_i,
    output payload_t           rdata_o,
    output logic               full_o,
    output logic               empty_o,
    output logic [DEPTH_POT:0] count_o
);
    localparam int DEPTH = 1 << DEPTH_POT;

    payload_t           mem [DEPTH];
    // pointers carry one wrap bit above the index
    logic [DEPTH_POT:0] wr_ptr_q;
    logic [DEPTH_POT:0] rd_ptr_q;
    logic               do_wr;
    logic               do_rd;

    // same index, different wrap bit means full
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[DEPTH_POT] != rd_ptr_q[DEPTH_POT])
                  && (wr_ptr_q[DEPTH_POT-1:0] == rd_ptr_q[DEPTH_POT-1:0]);
    assign count_o = wr_ptr_q - rd_ptr_q;

    // head is shown combinationally, first word fall-through
    assign rdata_o = mem[rd_ptr_q[DEPTH_POT-1:0]];

    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    always_ff @(posedge clk_i)
    begin
        if (do_wr)
        begin
            mem[wr_ptr_q[DEPTH_POT-1:0]] <= wdata_i;
        end
    end

    // clear wins over a write or read in the same cycle
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i || clear_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_rd)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // the producer paces itself against full
    a_no_wr_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(wr_i && full_o && !clear_i));

    // the consumer only reads a presented word
    a_no_rd_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rd_i |-> !empty_o);

endmodule

// ==== verilog/fetch_trap_csr.sv ====
//////////////////////////////////////////////////
// mtvec and mepc registers, trap target and
// redirect target selection
//////////////////////////////////////////////////

`include "fetch_params.svh"

module fetch_trap_csr (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  fetch_pkg::csr_wr_t   csr_wr_i,
    input  fetch_pkg::mcause_t   mcause_i,
    input  fetch_pkg::redirect_t redirect_i,
    output logic [31:0]          new_pc_o
);
    fetch_pkg::mtvec_t mtvec_q;
    logic [31:0]       mepc_q;
    logic [31:0]       trap_target;

    // writes visible from the next cycle on
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            mtvec_q <= '0;
            mepc_q  <= '0;
        end
        else if (csr_wr_i.we)
        begin
            if (csr_wr_i.addr == `CSR_ADDR_MTVEC)
            begin
                mtvec_q.base <= csr_wr_i.data[31:2];
                mtvec_q.mode <= fetch_pkg::mtvec_mode_t'(csr_wr_i.data[1:0]);
            end
            // no compressed isa so mepc[1:0] reads as zero
            if (csr_wr_i.addr == `CSR_ADDR_MEPC)
                mepc_q <= {csr_wr_i.data[31:2], 2'b00};
        end
    end

    // vectored mode offsets the base by one word per trap code
    // reserved modes behave as direct
    always_comb
    begin
        case (mtvec_q.mode)
            fetch_pkg::MTVEC_VECTORED:
                trap_target = {mtvec_q.base + 30'(mcause_i.trap_code), 2'b00};
            default:
                trap_target = {mtvec_q.base, 2'b00};
        endcase
    end

    // target is only sampled by the prefetcher when redirect_i.en is set
    always_comb
    begin
        case (redirect_i.sel)
            fetch_pkg::PC_MEPC: new_pc_o = mepc_q;
            fetch_pkg::PC_TRAP: new_pc_o = trap_target;
            default:            new_pc_o = redirect_i.branch_target;
        endcase
    end

endmodule

// ==== verilog/wb_prefetch.sv ====
//////////////////////////////////////////////////
// wishbone pipelined fetch master with request pacing,
// ignored-ack tracking and architectural pc
//////////////////////////////////////////////////

`include "fetch_params.svh"

module wb_prefetch #(
    parameter int BUF_POT = `FETCH_BUF_POT
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    output fetch_pkg::wb_req_t    wb_req_o,
    input  fetch_pkg::wb_rsp_t    wb_rsp_i,
    output fetch_pkg::fetch_out_t fetch_o,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  redirect_en_i,
    input  logic [31:0]           new_pc_i,
    output logic                  ff_wr_o,
    output logic                  ff_rd_o,
    output logic                  ff_clear_o,
    input  logic                  ff_empty_i,
    input  logic [BUF_POT:0]      ff_count_i,
    input  logic [31:0]           ff_rdata_i
);
    // one spare bit so occupancy sums cannot wrap
    localparam int            CW    = BUF_POT + 2;
    localparam logic [CW-1:0] DEPTH = CW'(1 << BUF_POT);

    typedef enum logic [1:0] {
        BOOT,
        REQUESTING,
        BUFFER_FULL
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic             stb;
    logic             cyc;
    logic             accept;
    logic             restart;
    logic [31:0]      restart_pc;
    logic [31:0]      fetch_pc_q;
    logic [31:0]      fetch_pc_d;
    logic [31:0]      arch_pc_q;
    logic [31:0]      arch_pc_d;
    // acks whose words will be kept
    logic [BUF_POT:0] pending_q;
    logic [BUF_POT:0] pending_d;
    // acks owed to requests from before a redirect or flush
    logic [BUF_POT:0] ignore_q;
    logic [BUF_POT:0] ignore_d;
    logic [CW-1:0]    fifo_next;
    logic [CW-1:0]    used_next;

    assign accept  = stb && !wb_rsp_i.stall;
    assign restart = redirect_en_i || flush_i;

    // a flush refetches from the pc the cpu is looking at
    assign restart_pc = redirect_en_i ? new_pc_i : arch_pc_q;

    assign ff_clear_o = restart;
    assign ff_wr_o    = wb_rsp_i.ack && (ignore_q == '0);
    assign ff_rd_o    = !ff_empty_i && !stall_i;

    // ack settles first, then the new request, then a restart
    // moves everything still useful over to the ignore count
    always_comb
    begin
        pending_d = pending_q;
        ignore_d  = ignore_q;
        if (wb_rsp_i.ack)
        begin
            if (ignore_q != '0)
                ignore_d = ignore_q - 1'b1;
            else
                pending_d = pending_q - 1'b1;
        end
        if (accept)
            pending_d = pending_d + 1'b1;
        if (restart)
        begin
            ignore_d  = ignore_d + pending_d;
            pending_d = '0;
        end
    end

    // buffer occupancy next cycle, clear drops the write too
    assign fifo_next = restart ? '0 : CW'(ff_count_i) + CW'(ff_wr_o) - CW'(ff_rd_o);
    assign used_next = CW'(pending_d) + CW'(ignore_d) + fifo_next;

    // only issue a request if its word has a slot reserved
    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            BOOT:
                state_d = REQUESTING;
            REQUESTING, BUFFER_FULL:
                state_d = (used_next < DEPTH) ? REQUESTING : BUFFER_FULL;
            default:
                state_d = BOOT;
        endcase
    end

    assign stb = (state_q == REQUESTING);
    // cycle stays open until every owed ack is back
    assign cyc = stb || (pending_q != '0) || (ignore_q != '0);

    // address held under bus stall
    always_comb
    begin
        fetch_pc_d = fetch_pc_q;
        if (restart)
            fetch_pc_d = restart_pc;
        else if (accept)
            fetch_pc_d = fetch_pc_q + 32'd4;
    end

    always_comb
    begin
        arch_pc_d = arch_pc_q;
        if (redirect_en_i)
            arch_pc_d = new_pc_i;
        else if (ff_rd_o && !flush_i)
            arch_pc_d = arch_pc_q + 32'd4;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q    <= BOOT;
            fetch_pc_q <= `FETCH_BOOT_PC;
            arch_pc_q  <= `FETCH_BOOT_PC;
            pending_q  <= '0;
            ignore_q   <= '0;
        end
        else
        begin
            state_q    <= state_d;
            fetch_pc_q <= fetch_pc_d;
            arch_pc_q  <= arch_pc_d;
            pending_q  <= pending_d;
            ignore_q   <= ignore_d;
        end
    end

    // read-only master, full word lanes
    assign wb_req_o = '{cyc: cyc, stb: stb, we: 1'b0, sel: 4'hf,
                        addr: fetch_pc_q, wdata: '0};

    assign fetch_o = '{valid: !ff_empty_i, instr: ff_rdata_i, pc: arch_pc_q};

    // pacing keeps all owed acks within the buffer depth
    a_outstanding_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (CW'(pending_q) + CW'(ignore_q)) <= DEPTH);

    // slave never acks more than was accepted
    a_ack_owed: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_rsp_i.ack |-> ((pending_q != '0) || (ignore_q != '0)));

endmodule

// ==== verilog/fetch_top.sv ====
//////////////////////////////////////////////////
// fetch subsystem top: trap csr, prefetcher, buffer
//////////////////////////////////////////////////

`include "fetch_params.svh"

module fetch_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    output fetch_pkg::wb_req_t    wb_req_o,
    input  fetch_pkg::wb_rsp_t    wb_rsp_i,
    output fetch_pkg::fetch_out_t fetch_o,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  fetch_pkg::mcause_t    mcause_i,
    input  fetch_pkg::csr_wr_t    csr_wr_i
);
    logic [31:0]             new_pc;
    logic                    ff_wr;
    logic                    ff_rd;
    logic                    ff_clear;
    logic                    ff_empty;
    logic [`FETCH_BUF_POT:0] ff_count;
    logic [31:0]             ff_rdata;

    // redirect target source
    fetch_trap_csr i_csr (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .csr_wr_i   (csr_wr_i),
        .mcause_i   (mcause_i),
        .redirect_i (redirect_i),
        .new_pc_o   (new_pc)
    );

    wb_prefetch #(
        .BUF_POT (`FETCH_BUF_POT)
    ) i_prefetch (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .wb_req_o      (wb_req_o),
        .wb_rsp_i      (wb_rsp_i),
        .fetch_o       (fetch_o),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .redirect_en_i (redirect_i.en),
        .new_pc_i      (new_pc),
        .ff_wr_o       (ff_wr),
        .ff_rd_o       (ff_rd),
        .ff_clear_o    (ff_clear),
        .ff_empty_i    (ff_empty),
        .ff_count_i    (ff_count),
        .ff_rdata_i    (ff_rdata)
    );

    // returned words go straight from the bus into the buffer
    // full is not needed outside, pacing already reserves slots
    sync_fifo #(
        .payload_t (logic [31:0]),
        .DEPTH_POT (`FETCH_BUF_POT)
    ) i_buf (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (ff_clear),
        .wr_i    (ff_wr),
        .wdata_i (wb_rsp_i.rdata),
        .rd_i    (ff_rd),
        .rdata_o (ff_rdata),
        .full_o  (),
        .empty_o (ff_empty),
        .count_o (ff_count)
    );

endmodule

// ==== tests/tb_clock.sv ====
//////////////////////////////////////////////////
// testbench clock and reset generator
//////////////////////////////////////////////////

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rstn_o
);
    initial
    begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // release away from the sampling edge
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== tests/tb_wb_slave.sv ====
//////////////////////////////////////////////////
// wishbone pipelined read slave, random stall and
// ack delay, data is the inverted address
//////////////////////////////////////////////////

module tb_wb_slave (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  fetch_pkg::wb_req_t wb_req_i,
    output fetch_pkg::wb_rsp_t wb_rsp_o,
    input  logic               stall_i,
    input  logic [1:0]         delay_i
);
    // accepted addresses and the cycle from which each may be acked
    logic [31:0] addr_q [$];
    int          due_q [$];
    int          cycle = 0;
    logic        ack_q = 1'b0;
    logic [31:0] rdata_q = '0;

    // stall comes straight from the testbench driver
    assign wb_rsp_o = '{ack: ack_q, stall: stall_i, rdata: rdata_q};

    // bookkeeping on the rising edge where the request is stable
    always @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            addr_q.delete();
            due_q.delete();
            cycle = 0;
        end
        else
        begin
            // the ack shown this cycle retires the oldest request
            if (ack_q)
            begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (wb_req_i.cyc && wb_req_i.stb && !stall_i)
            begin
                addr_q.push_back(wb_req_i.addr);
                due_q.push_back(cycle + 1 + int'(delay_i));
            end
            cycle = cycle + 1;
        end
    end

    // responses change on the falling edge, one ack per cycle, in order
    always @(negedge clk_i)
    begin
        if (rstn_i && (addr_q.size() > 0) && (cycle >= due_q[0]))
        begin
            ack_q   = 1'b1;
            rdata_q = ~addr_q[0];
        end
        else
        begin
            ack_q   = 1'b0;
            rdata_q = '0;
        end
    end

endmodule

// ==== tests/tb_fetch.sv ====
//////////////////////////////////////////////////
// fetch testbench with stimulus, reference pc model,
// checking assertions, watchdog and report
//////////////////////////////////////////////////

`include "fetch_params.svh"

module tb_fetch;
    localparam int PERIOD      = 100;
    localparam int TEST_CYCLES = 400;
    // each of these phases lasts at most TEST_CYCLES
    localparam int PHASES      = 10;
    localparam int WATCHDOG    = PHASES * TEST_CYCLES * PERIOD * 3 / 2;
    localparam int DEPTH       = 1 << `FETCH_BUF_POT;

    logic                  clk;
    logic                  rstn;
    fetch_pkg::wb_req_t    wb_req;
    fetch_pkg::wb_rsp_t    wb_rsp;
    fetch_pkg::fetch_out_t fetch;
    logic                  stall;
    logic                  flush;
    fetch_pkg::redirect_t  redirect;
    fetch_pkg::mcause_t    mcause;
    fetch_pkg::csr_wr_t    csr_wr;
    logic                  bus_stall;
    logic [1:0]            ack_delay;
    logic                  hold_stall;
    logic [31:0]           lfsr;
    logic [31:0]           ref_target;
    logic [31:0]           exp_pc;
    logic                  consume;
    logic                  held;
    logic                  prev_held;
    logic [31:0]           prev_pc;
    logic [31:0]           prev_instr;
    logic                  seen_req;
    int                    outstanding;
    int                    words;
    int                    errors;
    int                    tests_run;

    tb_clock #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (2)
    ) i_clock (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    tb_wb_slave i_slave (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .stall_i  (bus_stall),
        .delay_i  (ack_delay)
    );

    fetch_top i_dut (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .wb_req_o   (wb_req),
        .wb_rsp_i   (wb_rsp),
        .fetch_o    (fetch),
        .stall_i    (stall),
        .flush_i    (flush),
        .redirect_i (redirect),
        .mcause_i   (mcause),
        .csr_wr_i   (csr_wr)
    );

    // a word shown in a redirect or flush cycle is dropped rather than consumed
    assign consume = fetch.valid && !stall && !redirect.en && !flush;
    assign held    = fetch.valid && stall && !redirect.en && !flush;

    // reference model of expected pc, words taken and requests owed an ack
    // a flush keeps the expected pc so refetch starts where the cpu stood
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            exp_pc      <= `FETCH_BOOT_PC;
            outstanding <= 0;
            words       <= 0;
            seen_req    <= 1'b0;
            prev_held   <= 1'b0;
            prev_pc     <= '0;
            prev_instr  <= '0;
        end
        else
        begin
            if (redirect.en)
                exp_pc <= ref_target;
            else if (consume)
                exp_pc <= exp_pc + 32'd4;
            if (consume)
                words <= words + 1;
            outstanding <= outstanding + int'(wb_req.cyc && wb_req.stb && !wb_rsp.stall)
                         - int'(wb_rsp.ack);
            if (wb_req.stb)
                seen_req <= 1'b1;
            prev_held  <= held;
            prev_pc    <= fetch.pc;
            prev_instr <= fetch.instr;
        end
    end

    // first request after reset carries the boot pc
    a_boot_pc: assert property (@(posedge clk) disable iff (!rstn)
        (wb_req.stb && !seen_req) |-> (wb_req.addr == `FETCH_BOOT_PC))
    else
    begin
        $display("CHECK FAILED wb_req_o.addr: got %h, expected %h",
                 $sampled(wb_req.addr), `FETCH_BOOT_PC);
        errors = errors + 1;
    end

    // fetch requests are full word reads inside an open cycle
    a_bus_read: assert property (@(posedge clk) disable iff (!rstn)
        wb_req.stb |-> (wb_req.cyc && !wb_req.we && (wb_req.sel == 4'hf)))
    else
    begin
        $display("CHECK FAILED wb_req_o: cyc %h we %h sel %h, expected 1 0 f",
                 $sampled(wb_req.cyc), $sampled(wb_req.we), $sampled(wb_req.sel));
        errors = errors + 1;
    end

    // consumed pc follows the stream or the redirect target
    a_pc: assert property (@(posedge clk) disable iff (!rstn)
        consume |-> (fetch.pc == exp_pc))
    else
    begin
        $display("CHECK FAILED fetch_o.pc: got %h, expected %h",
                 $sampled(fetch.pc), $sampled(exp_pc));
        errors = errors + 1;
    end

    a_instr: assert property (@(posedge clk) disable iff (!rstn)
        consume |-> (fetch.instr == ~exp_pc))
    else
    begin
        $display("CHECK FAILED fetch_o.instr: got %h, expected %h",
                 $sampled(fetch.instr), ~$sampled(exp_pc));
        errors = errors + 1;
    end

    // a redirect or flush empties the buffer in its own cycle
    a_clear: assert property (@(posedge clk) disable iff (!rstn)
        (redirect.en || flush) |=> !fetch.valid)
    else
    begin
        $display("CHECK FAILED fetch_o.valid after clear: got %h, expected 0",
                 $sampled(fetch.valid));
        errors = errors + 1;
    end

    // a stalled word stays on the port unchanged
    a_hold_pc: assert property (@(posedge clk) disable iff (!rstn)
        prev_held |-> (fetch.valid && (fetch.pc == prev_pc)))
    else
    begin
        $display("CHECK FAILED fetch_o.pc under stall: valid %h, got %h, held %h",
                 $sampled(fetch.valid), $sampled(fetch.pc), $sampled(prev_pc));
        errors = errors + 1;
    end

    a_hold_instr: assert property (@(posedge clk) disable iff (!rstn)
        prev_held |-> (fetch.instr == prev_instr))
    else
    begin
        $display("CHECK FAILED fetch_o.instr under stall: got %h, held %h",
                 $sampled(fetch.instr), $sampled(prev_instr));
        errors = errors + 1;
    end

    a_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        outstanding <= DEPTH)
    else
    begin
        $display("CHECK FAILED outstanding requests: got %h, limit %h",
                 $sampled(outstanding), DEPTH);
        errors = errors + 1;
    end

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // at the next falling edge draw new stalls and delay and drop the pulses
    task automatic step();
        logic [7:0] r;
        @(negedge clk);
        rand_bits(2, r);
        bus_stall = r[1] & r[0];
        rand_bits(2, r);
        ack_delay = r[1:0];
        rand_bits(2, r);
        stall     = hold_stall || (r[1] & r[0]);
        flush     = 1'b0;
        redirect  = '0;
        csr_wr    = '0;
    endtask

    task automatic run_words(input int n, input string name);
        int target;
        int cycles;
        target = words + n;
        cycles = 0;
        while ((words < target) && (cycles < TEST_CYCLES))
        begin
            step();
            cycles = cycles + 1;
        end
        if (words < target)
        begin
            $display("%s: only %0d of %0d words arrived within %0d cycles",
                     name, n - (target - words), n, cycles);
            errors = errors + 1;
        end
    endtask

    // wait for requests in flight or for a word on the port
    task automatic wait_ready(input bit need_outstanding, input string name);
        int cycles;
        cycles = 0;
        while (!(need_outstanding ? (outstanding != 0) : fetch.valid)
               && (cycles < TEST_CYCLES))
        begin
            step();
            cycles = cycles + 1;
        end
        if (cycles >= TEST_CYCLES)
        begin
            $display("%s: fetch never became ready for the redirect", name);
            errors = errors + 1;
        end
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        step();
        csr_wr = '{we: 1'b1, addr: addr, data: data};
    endtask

    task automatic redirect_to(input fetch_pkg::pc_sel_t sel, input logic [31:0] branch,
                               input logic [31:0] expected);
        step();
        redirect   = '{en: 1'b1, sel: sel, branch_target: branch};
        ref_target = expected;
    endtask

    task automatic report(input string name, input int err_before);
        tests_run = tests_run + 1;
        $display("test %0d %s finished with %0d errors, %0d words consumed",
                 tests_run, name, errors - err_before, words);
    endtask

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        int          err_before;
        logic [31:0] tvec;
        lfsr       = 32'h97c2;
        stall      = 1'b0;
        flush      = 1'b0;
        redirect   = '0;
        mcause     = '0;
        csr_wr     = '0;
        bus_stall  = 1'b0;
        ack_delay  = '0;
        hold_stall = 1'b0;
        ref_target = '0;
        errors     = 0;
        tests_run  = 0;
        wait (rstn === 1'b1);

        // sequential stream from the boot pc
        err_before = errors;
        run_words(40, "boot stream");
        report("boot stream", err_before);

        // jump while acks are still owed
        err_before = errors;
        wait_ready(1'b1, "jump");
        redirect   = '{en: 1'b1, sel: fetch_pkg::PC_JUMP, branch_target: 32'h0000_1000};
        ref_target = 32'h0000_1000;
        run_words(16, "jump");
        report("jump", err_before);

        // direct then vectored trap with cause 5
        err_before = errors;
        tvec = 32'h0000_2000;
        write_csr(`CSR_ADDR_MTVEC, tvec);
        mcause = '{interrupt: 1'b1, trap_code: 31'd5};
        redirect_to(fetch_pkg::PC_TRAP, 32'h0, 32'h0000_2000);
        run_words(8, "trap direct");
        tvec = 32'h0000_3001;
        write_csr(`CSR_ADDR_MTVEC, tvec);
        // base 32'h3000 plus five words
        redirect_to(fetch_pkg::PC_TRAP, 32'h0, 32'h0000_3014);
        run_words(8, "trap vectored");
        report("trap", err_before);

        err_before = errors;
        write_csr(`CSR_ADDR_MEPC, 32'h0000_4100);
        redirect_to(fetch_pkg::PC_MEPC, 32'h0, 32'h0000_4100);
        run_words(8, "mret");
        report("mret", err_before);

        // refetch from the pc on the port
        err_before = errors;
        wait_ready(1'b0, "flush");
        flush = 1'b1;
        run_words(12, "flush");
        report("flush", err_before);

        // cpu stalled long enough to fill the buffer
        err_before = errors;
        hold_stall = 1'b1;
        repeat (TEST_CYCLES / 4) step();
        hold_stall = 1'b0;
        run_words(16, "stall hold");
        report("stall hold", err_before);

        $display("summary: %0d tests, %0d words consumed, %0d errors", tests_run, words, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/sync_fifo.sv
verilog/fetch_trap_csr.sv
verilog/wb_prefetch.sv
verilog/fetch_top.sv
tests/tb_clock.sv
tests/tb_wb_slave.sv
tests/tb_fetch.sv

// ==== Makefile ====
# Verilator lint and simulation of the fetch subsystem

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LINTFLAGS ?= --lint-only --timing
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
